//--- verilog/cnn_ctrl_macros.svh
`ifndef CNN_CTRL_MACROS_SVH
`define CNN_CTRL_MACROS_SVH

// datapath geometry seen by the decoder
`define CNN_PARA_XY 3 // feature-map tile edge, pixels per beat row
`define CNN_KERNEL_MAX 3 // largest kernel edge, one weight beat is KMAX x KMAX

// descriptor table
`define CNN_LAYER_MAX 4 // entries, also the hard stop for a run

// axi4-lite register map, byte offsets
`define CNN_AXI_ADDR_W 8 // enough for control, status and the table
`define CNN_REG_CTRL 'h00 // bit 0 start, self clearing
`define CNN_REG_STATUS 'h04 // busy, done, error, layers
`define CNN_REG_BEATS 'h08 // accepted beat total
`define CNN_REG_DESC 'h10 // descriptor i at +4i

// axi response codes
`define CNN_RESP_OKAY 2'b00
`define CNN_RESP_SLVERR 2'b10

`endif

//--- verilog/cnn_ctrl_pkg.sv
package cnn_ctrl_pkg;

	typedef logic [31:0] desc_t; // raw descriptor word as written by the host
	typedef logic [7:0] dim_t; // fm edge or kernel count
	typedef logic [3:0] depth_t; // channel depth or kernel edge
	typedef logic [15:0] beat_cnt_t; // beat counts and beat numbers
	typedef logic [1:0] layer_idx_t; // table index

	typedef enum logic [3:0] {
		lt_prepare = 4'd0, // load init data, not run by this sequencer
		lt_conv = 4'd1,
		lt_pool = 4'd2,
		lt_fc = 4'd3,
		lt_finish = 4'd9 // ends the run
	} layer_type_e;

	typedef enum logic [1:0] {
		bk_fm, // feature-map load
		bk_weight, // weight load
		bk_out // output beat
	} beat_kind_e;

	typedef enum logic [2:0] {
		st_idle,
		st_decode, // one cycle per layer
		st_load_fm,
		st_load_wt,
		st_emit_out,
		st_done // run_end cycle
	} seq_state_e;

	typedef struct packed {
		layer_type_e layer_type;
		dim_t fm_size;
		depth_t fm_depth;
		depth_t kernel_size;
		dim_t kernel_num;
		logic pool_type; // 0 max, 1 avg
		logic relu;
		beat_cnt_t fm_beats;
		beat_cnt_t wt_beats;
		beat_cnt_t out_beats;
		logic legal;
	} layer_cfg_t;

	typedef struct packed {
		beat_kind_e kind;
		layer_idx_t layer;
		beat_cnt_t num; // restarts at zero for each kind
	} beat_t;

endpackage

//--- verilog/cnn_axil_regs.sv
`timescale 1ns/1ps

`include "cnn_ctrl_macros.svh"

module cnn_axil_regs (
	input logic clk,
	input logic rst,
	input logic [`CNN_AXI_ADDR_W-1:0] awaddr,
	input logic awvalid,
	output logic awready,
	input logic [31:0] wdata,
	input logic [3:0] wstrb,
	input logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,
	input logic [`CNN_AXI_ADDR_W-1:0] araddr,
	input logic arvalid,
	output logic arready,
	output logic [31:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready,
	output logic start,
	input cnn_ctrl_pkg::layer_idx_t rd_idx,
	output cnn_ctrl_pkg::desc_t rd_desc,
	input logic busy,
	input logic done,
	input logic error,
	input cnn_ctrl_pkg::dim_t layers,
	input cnn_ctrl_pkg::beat_cnt_t beats
);
	import cnn_ctrl_pkg::*;

	desc_t table_q [0:`CNN_LAYER_MAX-1]; // descriptor table, no reset
	logic wr_fire; // aw and w taken together
	logic rd_fire;
	logic wr_ok; // address is mapped
	logic rd_ok;
	logic done_lvl; // status done bit, held until next start
	layer_idx_t wr_sel;
	layer_idx_t rd_sel;
	logic [31:0] rd_word;

	function automatic logic is_desc(input logic [`CNN_AXI_ADDR_W-1:0] addr);
		return (addr >= `CNN_REG_DESC) && (addr < `CNN_REG_DESC + 4 * `CNN_LAYER_MAX);
	endfunction

	assign awready = awvalid & wvalid & ~bvalid; // both channels at once, one write in flight
	assign wready = awready;
	assign wr_fire = awready;
	assign arready = ~rvalid; // next read only after rdata is taken
	assign rd_fire = arvalid & arready;

	assign wr_sel = layer_idx_t'((awaddr - `CNN_REG_DESC) >> 2);
	assign rd_sel = layer_idx_t'((araddr - `CNN_REG_DESC) >> 2);
	assign rd_desc = table_q[rd_idx]; // sequencer port, combinational

	assign wr_ok = (awaddr == `CNN_REG_CTRL) || (awaddr == `CNN_REG_STATUS) ||
		(awaddr == `CNN_REG_BEATS) || is_desc(awaddr);

	always_comb begin
		rd_word = '0; // unmapped reads return zero
		rd_ok = 1'b1;
		if (araddr == `CNN_REG_CTRL) begin
			rd_word = '0; // start bit self clears
		end else if (araddr == `CNN_REG_STATUS) begin
			rd_word = {16'd0, layers, 5'd0, error, done_lvl, busy};
		end else if (araddr == `CNN_REG_BEATS) begin
			rd_word = {16'd0, beats};
		end else if (is_desc(araddr)) begin
			rd_word = table_q[rd_sel];
		end else begin
			rd_ok = 1'b0; // slverr
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			bvalid <= 1'b0;
			rvalid <= 1'b0;
			start <= 1'b0;
			done_lvl <= 1'b0;
		end else begin
			// start pulse, dropped while a run is active
			start <= wr_fire && (awaddr == `CNN_REG_CTRL) && wstrb[0] && wdata[0] &&
				!busy && !start;
			if (wr_fire)
				bvalid <= 1'b1; // response the cycle after aw+w
			else if (bready)
				bvalid <= 1'b0;
			if (rd_fire)
				rvalid <= 1'b1;
			else if (rready)
				rvalid <= 1'b0;
			if (start)
				done_lvl <= 1'b0; // new run clears done
			else if (done)
				done_lvl <= 1'b1;
		end
	end

	// payload side, table writes honour byte strobes
	always_ff @(posedge clk) begin
		if (wr_fire) begin
			bresp <= wr_ok ? `CNN_RESP_OKAY : `CNN_RESP_SLVERR;
			if (is_desc(awaddr)) begin
				for (int b = 0; b < 4; b++) begin
					if (wstrb[b])
						table_q[wr_sel][8*b +: 8] <= wdata[8*b +: 8];
				end
			end
		end
		if (rd_fire) begin
			rdata <= rd_word;
			rresp <= rd_ok ? `CNN_RESP_OKAY : `CNN_RESP_SLVERR;
		end
	end

endmodule

//--- verilog/cnn_layer_decode.sv
`timescale 1ns/1ps

`include "cnn_ctrl_macros.svh"

module cnn_layer_decode (
	input cnn_ctrl_pkg::desc_t desc,
	output cnn_ctrl_pkg::layer_cfg_t cfg
);
	import cnn_ctrl_pkg::*;

	logic [31:0] tiles; // ceil(fm_size / para), per edge
	logic [31:0] pool_tiles; // same for the halved map
	logic [31:0] fc_slices; // weight beats per fc kernel
	logic [31:0] fm_raw;
	logic [31:0] wt_raw;
	logic [31:0] out_raw;
	logic kernel_ok; // kernel_num check where the type needs one

	always_comb begin
		// field split, layout fixed by the host driver
		cfg.layer_type = layer_type_e'(desc[3:0]);
		cfg.fm_size = desc[11:4];
		cfg.fm_depth = desc[15:12];
		cfg.kernel_size = desc[19:16];
		cfg.kernel_num = desc[27:20];
		cfg.pool_type = desc[28];
		cfg.relu = desc[29];

		tiles = (32'(cfg.fm_size) + `CNN_PARA_XY - 1) / `CNN_PARA_XY;
		pool_tiles = (32'(cfg.fm_size) / 2 + `CNN_PARA_XY - 1) / `CNN_PARA_XY; // 2x2 window
		fc_slices = (32'(cfg.fm_size) * 32'(cfg.fm_size) * 32'(cfg.fm_depth) +
			`CNN_KERNEL_MAX * `CNN_KERNEL_MAX - 1) / (`CNN_KERNEL_MAX * `CNN_KERNEL_MAX);

		fm_raw = tiles * tiles * 32'(cfg.fm_depth); // same load for every legal type
		wt_raw = '0;
		out_raw = '0;
		kernel_ok = 1'b0;
		case (cfg.layer_type)
			lt_conv: begin
				wt_raw = 32'(cfg.kernel_num) * 32'(cfg.fm_depth); // one slice per kernel per channel
				out_raw = tiles * tiles * 32'(cfg.kernel_num);
				kernel_ok = (cfg.kernel_num != '0);
			end
			lt_pool: begin
				out_raw = pool_tiles * pool_tiles * 32'(cfg.fm_depth); // no weights
				kernel_ok = 1'b1; // kernel_num unused by pool
			end
			lt_fc: begin
				wt_raw = 32'(cfg.kernel_num) * fc_slices;
				out_raw = (32'(cfg.kernel_num) + `CNN_PARA_XY - 1) / `CNN_PARA_XY;
				kernel_ok = (cfg.kernel_num != '0);
			end
			default: kernel_ok = 1'b0; // prepare, finish and unknown types
		endcase

		cfg.legal = kernel_ok && (cfg.fm_size != '0) && (cfg.fm_depth != '0);
		// illegal layers carry no beats
		cfg.fm_beats = cfg.legal ? beat_cnt_t'(fm_raw) : '0;
		cfg.wt_beats = cfg.legal ? beat_cnt_t'(wt_raw) : '0;
		cfg.out_beats = cfg.legal ? beat_cnt_t'(out_raw) : '0;
	end

endmodule

//--- verilog/cnn_layer_seq.sv
`timescale 1ns/1ps

`include "cnn_ctrl_macros.svh"

module cnn_layer_seq (
	input logic clk,
	input logic rst,
	input logic start,
	output cnn_ctrl_pkg::layer_idx_t rd_idx,
	input cnn_ctrl_pkg::desc_t rd_desc,
	output logic beat_valid,
	input logic beat_ready,
	output cnn_ctrl_pkg::beat_t beat,
	output logic layer_end,
	output logic skip,
	output logic run_end
);
	import cnn_ctrl_pkg::*;

	seq_state_e state;
	layer_idx_t idx; // current table entry
	layer_cfg_t cfg; // decoder output, live
	layer_cfg_t cfg_q; // held for the beat states
	beat_cnt_t fm_cnt;
	beat_cnt_t wt_cnt;
	beat_cnt_t out_cnt;
	beat_cnt_t cur_total; // beats of the kind being sent
	logic fire;
	logic beat_last; // last beat of this kind accepted
	logic layer_last; // last beat of the layer accepted
	logic last_idx;

	cnn_layer_decode u_decode (
		.desc(rd_desc),
		.cfg(cfg)
	);

	assign rd_idx = idx;
	assign fire = beat_valid & beat_ready;
	assign last_idx = (idx == layer_idx_t'(`CNN_LAYER_MAX - 1)); // table exhausted after this
	assign skip = (state == st_decode) && (cfg.layer_type != lt_finish) && !cfg.legal;
	assign run_end = (state == st_done);

	always_comb begin
		beat_valid = 1'b1;
		beat.layer = idx;
		beat.kind = bk_fm;
		beat.num = fm_cnt;
		cur_total = cfg_q.fm_beats;
		case (state)
			st_load_fm: ; // defaults above
			st_load_wt: begin
				beat.kind = bk_weight;
				beat.num = wt_cnt;
				cur_total = cfg_q.wt_beats;
			end
			st_emit_out: begin
				beat.kind = bk_out;
				beat.num = out_cnt;
				cur_total = cfg_q.out_beats;
			end
			default: beat_valid = 1'b0;
		endcase
	end

	assign beat_last = fire && (beat_cnt_t'(beat.num + 16'd1) == cur_total);
	// zero-count kinds are passed over, so the layer can end in any beat state
	assign layer_last = beat_last && ((state == st_emit_out) ||
		((state == st_load_wt) && (cfg_q.out_beats == '0)) ||
		((state == st_load_fm) && (cfg_q.wt_beats == '0) && (cfg_q.out_beats == '0)));

	always_ff @(posedge clk) begin
		if (state == st_decode)
			cfg_q <= cfg;
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= st_idle;
			idx <= '0;
			fm_cnt <= '0;
			wt_cnt <= '0;
			out_cnt <= '0;
			layer_end <= 1'b0;
		end else begin
			layer_end <= layer_last; // pulse the cycle after the last beat
			case (state)
				st_idle: begin
					if (start) begin
						idx <= '0;
						state <= st_decode;
					end
				end
				st_decode: begin
					fm_cnt <= '0;
					wt_cnt <= '0;
					out_cnt <= '0;
					if (cfg.layer_type == lt_finish) begin
						state <= st_done;
					end else if (!cfg.legal) begin
						idx <= idx + 2'd1; // skip, no beats
						state <= last_idx ? st_done : st_decode;
					end else if (cfg.fm_beats != '0) begin
						state <= st_load_fm;
					end else if (cfg.wt_beats != '0) begin
						state <= st_load_wt;
					end else begin
						state <= st_emit_out;
					end
				end
				st_load_fm, st_load_wt, st_emit_out: begin
					if (fire && (state == st_load_fm))
						fm_cnt <= fm_cnt + 16'd1;
					if (fire && (state == st_load_wt))
						wt_cnt <= wt_cnt + 16'd1;
					if (fire && (state == st_emit_out))
						out_cnt <= out_cnt + 16'd1;
					if (layer_last) begin
						idx <= idx + 2'd1;
						state <= last_idx ? st_done : st_decode;
					end else if (beat_last) begin
						// fm to weights when there are any, otherwise straight to outputs
						state <= ((state == st_load_fm) && (cfg_q.wt_beats != '0)) ?
							st_load_wt : st_emit_out;
					end
				end
				default: state <= st_idle; // st_done, run_end is high here
			endcase
		end
	end

endmodule

//--- verilog/cnn_layer_result.sv
`timescale 1ns/1ps

module cnn_layer_result (
	input logic clk,
	input logic rst,
	input logic start,
	input logic beat_valid,
	input logic beat_ready,
	input logic layer_end,
	input logic skip,
	input logic run_end,
	output logic busy,
	output logic done,
	output logic error,
	output cnn_ctrl_pkg::dim_t layers,
	output cnn_ctrl_pkg::beat_cnt_t beats
);

	logic busy_q; // run in progress

	// busy drops on the run_end cycle, together with the done pulse
	assign busy = busy_q & ~run_end;
	assign done = busy_q & run_end;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			busy_q <= 1'b0;
			error <= 1'b0;
			layers <= '0;
			beats <= '0;
		end else if (start) begin
			busy_q <= 1'b1; // visible the cycle after the pulse
			error <= 1'b0;
			layers <= '0;
			beats <= '0;
		end else begin
			if (run_end)
				busy_q <= 1'b0;
			if (skip)
				error <= 1'b1; // sticky until next start
			if (layer_end)
				layers <= layers + 8'd1;
			if (beat_valid && beat_ready)
				beats <= beats + 16'd1; // accepted beats only
		end
	end

endmodule

//--- verilog/cnn_ctrl_top.sv
`timescale 1ns/1ps

`include "cnn_ctrl_macros.svh"

module cnn_ctrl_top (
	input logic clk,
	input logic rst,
	input logic [`CNN_AXI_ADDR_W-1:0] awaddr,
	input logic awvalid,
	output logic awready,
	input logic [31:0] wdata,
	input logic [3:0] wstrb,
	input logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,
	input logic [`CNN_AXI_ADDR_W-1:0] araddr,
	input logic arvalid,
	output logic arready,
	output logic [31:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready,
	output logic beat_valid,
	input logic beat_ready,
	output cnn_ctrl_pkg::beat_t beat,
	output logic done
);
	import cnn_ctrl_pkg::*;

	logic start; // one-cycle run request
	layer_idx_t rd_idx;
	desc_t rd_desc;
	logic layer_end;
	logic skip;
	logic run_end;
	logic busy;
	logic error;
	dim_t layers;
	beat_cnt_t beats;

	cnn_axil_regs u_regs (
		.clk(clk), .rst(rst),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.start(start), .rd_idx(rd_idx), .rd_desc(rd_desc),
		.busy(busy), .done(done), .error(error), .layers(layers), .beats(beats)
	);

	cnn_layer_seq u_seq (
		.clk(clk), .rst(rst), .start(start),
		.rd_idx(rd_idx), .rd_desc(rd_desc),
		.beat_valid(beat_valid), .beat_ready(beat_ready), .beat(beat), // also seen by result
		.layer_end(layer_end), .skip(skip), .run_end(run_end)
	);

	cnn_layer_result u_result (
		.clk(clk), .rst(rst), .start(start),
		.beat_valid(beat_valid), .beat_ready(beat_ready),
		.layer_end(layer_end), .skip(skip), .run_end(run_end),
		.busy(busy), .done(done), .error(error), .layers(layers), .beats(beats)
	);

endmodule

//--- test/cnn_ctrl_tb.sv
`timescale 1ns/1ps

`include "cnn_ctrl_macros.svh"

module cnn_ctrl_tb;
	import cnn_ctrl_pkg::*;

	localparam int row_count = 5;

	logic clk;
	logic rst;
	logic [`CNN_AXI_ADDR_W-1:0] awaddr;
	logic awvalid;
	logic awready;
	logic [31:0] wdata;
	logic [3:0] wstrb;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	logic [`CNN_AXI_ADDR_W-1:0] araddr;
	logic arvalid;
	logic arready;
	logic [31:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;
	logic beat_valid;
	logic beat_ready;
	beat_t beat;
	logic done;

	string names [0:row_count-1];
	desc_t descs [0:row_count-1][0:`CNN_LAYER_MAX-1];
	bit stall [0:row_count-1]; // random back-pressure on the beat stream
	bit restart [0:row_count-1]; // second start written mid run
	beat_t exp_q [$]; // model beat sequence for one row
	int exp_layers;
	bit exp_err;
	logic [31:0] lfsr_q;
	int limit;
	int cycles;
	int beat_errs, count_errs, status_errs, resp_errs, desc_errs, other_errs;

	cnn_ctrl_top dut (
		.clk(clk), .rst(rst),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.beat_valid(beat_valid), .beat_ready(beat_ready), .beat(beat), .done(done)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk; // 40 ns period
	end

	// watchdog armed once the limit is known
	initial begin
		cycles = 0;
		wait (limit > 0);
		while (cycles < limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout, the run did not finish within %0d cycles", limit);
		$display("Done: errors found");
		$finish;
	end

	function automatic logic lfsr_bit(); // x^32 + x^22 + x^2 + x + 1
		logic fb;
		fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
		lfsr_q = {lfsr_q[30:0], fb};
		return fb;
	endfunction

	function automatic desc_t make_desc(input int kind, input int fm, input int depth,
		input int knum, input bit pool, input bit relu);
		desc_t d;
		d = '0;
		d[3:0] = kind[3:0];
		d[11:4] = fm[7:0];
		d[15:12] = depth[3:0];
		d[19:16] = 4'd3; // kernel edge has no effect on the counts
		d[27:20] = knum[7:0];
		d[28] = pool;
		d[29] = relu;
		return d;
	endfunction

	function automatic int ceil_div(input int a, input int b);
		return (a + b - 1) / b;
	endfunction

	function automatic void add_beats(input int layer, input beat_kind_e kind, input int n);
		beat_t b;
		for (int k = 0; k < n; k++) begin
			b.kind = kind;
			b.layer = layer_idx_t'(layer);
			b.num = beat_cnt_t'(k); // numbering restarts per kind
			exp_q.push_back(b);
		end
	endfunction

	// expected beats, layer count and error bit of one row
	function automatic void model_row(input int r);
		desc_t d;
		int ty, fm, dep, kn, tiles, ptiles, nfm, nwt, nout;
		bit legal;
		bit stop;
		exp_q.delete();
		exp_layers = 0;
		exp_err = 1'b0;
		stop = 1'b0;
		for (int i = 0; i < `CNN_LAYER_MAX; i++) begin
			d = descs[r][i];
			ty = d[3:0];
			fm = d[11:4];
			dep = d[15:12];
			kn = d[27:20];
			if (!stop && ty == 9) begin
				stop = 1'b1; // finish entry
			end else if (!stop) begin
				tiles = ceil_div(fm, `CNN_PARA_XY);
				nfm = tiles * tiles * dep;
				nwt = 0;
				nout = 0;
				legal = (fm != 0) && (dep != 0);
				case (ty)
					1: begin
						nwt = kn * dep;
						nout = tiles * tiles * kn;
						legal = legal && (kn != 0);
					end
					2: begin
						ptiles = ceil_div(fm / 2, `CNN_PARA_XY);
						nout = ptiles * ptiles * dep;
					end
					3: begin
						nwt = kn * ceil_div(fm * fm * dep, `CNN_KERNEL_MAX * `CNN_KERNEL_MAX);
						nout = ceil_div(kn, `CNN_PARA_XY);
						legal = legal && (kn != 0);
					end
					default: legal = 1'b0;
				endcase
				if (!legal) begin
					exp_err = 1'b1; // skipped with no beats
				end else begin
					exp_layers++;
					add_beats(i, bk_fm, nfm);
					add_beats(i, bk_weight, nwt);
					add_beats(i, bk_out, nout);
				end
			end
		end
	endfunction

	function automatic int calc_limit();
		int sum;
		sum = 0;
		for (int r = 0; r < row_count; r++) begin
			model_row(r);
			sum += 4 * exp_q.size() + 200;
		end
		return sum;
	endfunction

	task automatic fill_table();
		names[0] = "chain_ready";
		descs[0][0] = make_desc(1, 6, 2, 4, 1'b0, 1'b1); // conv 6x6x2 with 4 kernels
		descs[0][1] = make_desc(2, 4, 4, 0, 1'b1, 1'b0); // avg pool
		descs[0][2] = make_desc(3, 2, 4, 5, 1'b0, 1'b1); // fc with 5 outputs
		descs[0][3] = make_desc(9, 0, 0, 0, 1'b0, 1'b0);
		names[1] = "chain_stall";
		names[4] = "restart_busy";
		for (int i = 0; i < `CNN_LAYER_MAX; i++) begin
			descs[1][i] = descs[0][i];
			descs[4][i] = descs[0][i];
		end
		names[2] = "skip_illegal";
		descs[2][0] = make_desc(1, 3, 1, 2, 1'b0, 1'b0);
		descs[2][1] = make_desc(7, 3, 1, 2, 1'b0, 1'b0); // unknown type
		descs[2][2] = make_desc(2, 0, 2, 0, 1'b0, 1'b0); // zero fm_size
		descs[2][3] = make_desc(3, 3, 1, 4, 1'b0, 1'b1);
		names[3] = "four_legal";
		descs[3][0] = make_desc(1, 4, 2, 2, 1'b0, 1'b1);
		descs[3][1] = make_desc(2, 6, 2, 0, 1'b0, 1'b0);
		descs[3][2] = make_desc(1, 3, 3, 1, 1'b0, 1'b0);
		descs[3][3] = make_desc(3, 3, 2, 3, 1'b0, 1'b1); // no finish so the table runs out
		stall = '{1'b0, 1'b1, 1'b0, 1'b1, 1'b1};
		restart = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1};
	endtask

	task automatic check_beat(input string name, input beat_t exp, input beat_t act);
		if (act !== exp) begin
			beat_errs++;
			$display("Fail %s expected kind %0d layer %0d num %0d actual kind %0d layer %0d num %0d",
				name, exp.kind, exp.layer, exp.num, act.kind, act.layer, act.num);
		end
	endtask

	task automatic check_count(input string name, input beat_cnt_t exp, input beat_cnt_t act);
		if (act !== exp) begin
			count_errs++;
			$display("Fail %s expected %0d actual %0d", name, exp, act);
		end
	endtask

	task automatic check_status(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		if (act !== exp) begin
			status_errs++;
			$display("Fail %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic check_resp(input string name, input logic [1:0] exp, input logic [1:0] act);
		if (act !== exp) begin
			resp_errs++;
			$display("Fail %s expected %b actual %b", name, exp, act);
		end
	endtask

	task automatic check_desc(input string name, input desc_t exp, input desc_t act);
		if (act !== exp) begin
			desc_errs++;
			$display("Fail %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic axi_write(input logic [`CNN_AXI_ADDR_W-1:0] addr, input logic [31:0] data,
		input logic [3:0] strb, output logic [1:0] resp);
		@(negedge clk);
		awaddr = addr;
		wdata = data;
		wstrb = strb;
		awvalid = 1'b1;
		wvalid = 1'b1;
		bready = 1'b1;
		@(posedge clk);
		while (!(awready && wready))
			@(posedge clk); // aw and w are taken together on this edge
		@(negedge clk);
		awvalid = 1'b0;
		wvalid = 1'b0;
		while (!bvalid)
			@(negedge clk);
		resp = bresp;
	endtask

	task automatic axi_read(input logic [`CNN_AXI_ADDR_W-1:0] addr, output logic [31:0] data,
		output logic [1:0] resp);
		@(negedge clk);
		araddr = addr;
		arvalid = 1'b1;
		rready = 1'b1;
		@(posedge clk);
		while (!arready)
			@(posedge clk);
		@(negedge clk);
		arvalid = 1'b0;
		while (!rvalid)
			@(negedge clk);
		data = rdata;
		resp = rresp;
	endtask

	// samples the stream on the falling edge where it is stable
	task automatic watch_stream(input int r);
		beat_t exp_b; // model beat due on the stream
		bit held_v;
		bit rdy;
		bit seen_done;
		int idle; // cycles with valid low since the last accepted beat
		int prev_layer;
		int n;
		held_v = 1'b0;
		seen_done = 1'b0;
		idle = 0;
		prev_layer = 0;
		n = 0;
		while (!seen_done) begin
			@(negedge clk);
			seen_done = done;
			if (n < exp_q.size())
				exp_b = exp_q[n];
			if (held_v && !beat_valid) begin
				other_errs++;
				$display("%s: beat_valid dropped while the beat was stalled", names[r]);
			end else if (held_v && (n < exp_q.size())) begin
				check_beat({names[r], "/hold"}, exp_b, beat); // same beat until it is taken
			end
			rdy = stall[r] ? lfsr_bit() : 1'b1;
			beat_ready = rdy;
			held_v = beat_valid && !rdy;
			if (beat_valid && rdy) begin
				if (n >= exp_q.size()) begin
					other_errs++;
					$display("%s: more beats than the model expects", names[r]);
				end else begin
					check_beat({names[r], "/beat"}, exp_b, beat);
					// one decode cycle per table entry between layers and none inside a layer
					if (n > 0)
						check_count({names[r], "/gap"},
							beat_cnt_t'(int'(exp_b.layer) - prev_layer), beat_cnt_t'(idle));
					prev_layer = exp_b.layer;
				end
				idle = 0;
				n++;
			end else if (!beat_valid) begin
				idle++;
			end
		end
		check_count({names[r], "/beat_total"}, beat_cnt_t'(exp_q.size()), beat_cnt_t'(n));
	endtask

	task automatic run_row(input int r);
		logic [31:0] data;
		logic [1:0] resp;
		logic [1:0] resp2;
		for (int i = 0; i < `CNN_LAYER_MAX; i++) begin
			axi_write(`CNN_REG_DESC + 4 * i, descs[r][i], 4'hf, resp);
			check_resp({names[r], "/desc_wr"}, `CNN_RESP_OKAY, resp);
			axi_read(`CNN_REG_DESC + 4 * i, data, resp);
			check_desc({names[r], "/desc_rd"}, descs[r][i], data);
		end
		model_row(r);
		axi_write(`CNN_REG_CTRL, 32'd1, 4'h1, resp);
		check_resp({names[r], "/start"}, `CNN_RESP_OKAY, resp);
		if (restart[r]) begin
			fork
				watch_stream(r);
				begin
					repeat (8) @(negedge clk); // well inside the run
					axi_write(`CNN_REG_CTRL, 32'd1, 4'h1, resp2);
					check_resp({names[r], "/restart"}, `CNN_RESP_OKAY, resp2);
				end
			join
		end else begin
			watch_stream(r);
		end
		axi_read(`CNN_REG_STATUS, data, resp);
		check_status({names[r], "/status"},
			{16'd0, dim_t'(exp_layers), 5'd0, exp_err, 1'b1, 1'b0}, data); // done set and busy clear
		axi_read(`CNN_REG_BEATS, data, resp);
		check_count({names[r], "/beats_reg"}, beat_cnt_t'(exp_q.size()), data[15:0]);
	endtask

	task automatic axi_checks();
		logic [31:0] data;
		logic [1:0] resp;
		axi_read(`CNN_REG_STATUS, data, resp);
		check_status("axi/status_reset", 32'd0, data);
		axi_write(`CNN_REG_DESC + 4, 32'h1122_3344, 4'hf, resp);
		axi_write(`CNN_REG_DESC + 4, 32'haabb_ccdd, 4'b0101, resp); // bytes 0 and 2 only
		check_resp("axi/strb_wr", `CNN_RESP_OKAY, resp);
		axi_read(`CNN_REG_DESC + 4, data, resp);
		check_desc("axi/strb_rd", 32'h11bb_33dd, data);
		axi_write(8'h40, 32'hdead_beef, 4'hf, resp); // past the table
		check_resp("axi/unmapped_wr", `CNN_RESP_SLVERR, resp);
		axi_read(8'h44, data, resp);
		check_resp("axi/unmapped_rd", `CNN_RESP_SLVERR, resp);
		check_desc("axi/unmapped_data", 32'd0, data); // zero data
	endtask

	initial begin
		rst = 1'b0;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		beat_ready = 1'b0;
		lfsr_q = 32'h691c0426;
		beat_errs = 0;
		count_errs = 0;
		status_errs = 0;
		resp_errs = 0;
		desc_errs = 0;
		other_errs = 0;
		limit = 0;
		fill_table();
		limit = calc_limit();
		repeat (2) @(posedge clk); // reset held for two cycles
		@(negedge clk);
		rst = 1'b1;
		axi_checks();
		for (int r = 0; r < row_count; r++)
			run_row(r);
		$display("errors: beat %0d, count %0d, status %0d, resp %0d, desc %0d, other %0d",
			beat_errs, count_errs, status_errs, resp_errs, desc_errs, other_errs);
		if (beat_errs + count_errs + status_errs + resp_errs + desc_errs + other_errs == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

//--- cnn_ctrl_top.f
+incdir+verilog
verilog/cnn_ctrl_pkg.sv
verilog/cnn_axil_regs.sv
verilog/cnn_layer_decode.sv
verilog/cnn_layer_seq.sv
verilog/cnn_layer_result.sv
verilog/cnn_ctrl_top.sv
test/cnn_ctrl_tb.sv

//--- Bender.yml
package:
  name: cnn_ctrl

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/cnn_ctrl_pkg.sv
      - verilog/cnn_axil_regs.sv
      - verilog/cnn_layer_decode.sv
      - verilog/cnn_layer_seq.sv
      - verilog/cnn_layer_result.sv
      - verilog/cnn_ctrl_top.sv
      - target: test
        files:
          - test/cnn_ctrl_tb.sv
